/* src.f */
hw/mram_test_pkg.sv
hw/mram_test_seq.sv
hw/mram_bus_engine.sv
hw/report_uart.sv
hw/mram_tester_top.sv
verif/mram_model.sv
verif/tb_mram_tester.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the MRAM tester testbench, verdict from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_mram_tester -f src.f -o tb_sim \
    > build.log 2>&1 && ./obj_dir/tb_sim > sim.log 2>&1 || echo "build or simulation error"
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verif/tb_mram_tester.sv */
`timescale 1ns/10ps

module tb_mram_tester
    import mram_test_pkg::*;
();

    localparam logic [ADDR_W-1:0] BLOCK_FIRST  = 18'h00400;
    localparam logic [ADDR_W-1:0] BLOCK_LAST   = 18'h00403;
    localparam logic [LOOP_W-1:0] LOOP_COUNT   = 32'd2;
    localparam int                WR_PULSE     = 2;
    localparam int                RD_WAIT      = 2;
    localparam int                CLKS_PER_BIT = 4;
    localparam logic [ADDR_W-1:0] FAULT_ADDR   = 18'h00401;
    localparam logic [DATA_W-1:0] STUCK_MASK   = 16'h0009;

    localparam int NBLK    = int'(BLOCK_LAST - BLOCK_FIRST) + 1;
    localparam int RECORDS = 2 * NBLK * int'(LOOP_COUNT);     // write + read per block
    localparam int BIT_NS  = 4 * CLKS_PER_BIT;                // 4 ns clock
    localparam int TAIL    = 200;                             // quiet cycles after run_done
    localparam int LIMIT   = RECORDS * REPORT_BYTES * (10 * CLKS_PER_BIT + 4) + TAIL + 1000;

    logic              clk;
    logic              rst;
    logic              e_n;
    logic              w_n;
    logic              g_n;
    logic              ub_n;
    logic              lb_n;
    logic [ADDR_W-1:0] addr;
    wire  [7:0]        dqu;
    wire  [7:0]        dql;
    logic              tx;
    logic              fail;
    logic              run_done;

    int                wr_count;
    int                rd_count;
    int                rec_count;
    logic [DATA_W-1:0] model_word;     // last word seen on a read
    bit                nonzero_seen;   // a record with bad bits went out
    bit                run_seen;
    logic              w_prev;
    logic              g_prev;
    logic [7:0]        rec_bytes [$];

    mram_tester_top #(
        .BLOCK_FIRST (BLOCK_FIRST),
        .BLOCK_LAST  (BLOCK_LAST),
        .LOOP_COUNT  (LOOP_COUNT),
        .WR_PULSE    (WR_PULSE),
        .RD_WAIT     (RD_WAIT),
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) DUT (
        .clk     (clk),
        .rst     (rst),
        .e_n     (e_n),
        .w_n     (w_n),
        .g_n     (g_n),
        .ub_n    (ub_n),
        .lb_n    (lb_n),
        .addr    (addr),
        .dqu     (dqu),
        .dql     (dql),
        .tx      (tx),
        .fail    (fail),
        .run_done(run_done)
    );

    mram_model #(
        .FAULT_ADDR(FAULT_ADDR),
        .STUCK_MASK(STUCK_MASK)
    ) u_mram (
        .e_n (e_n),
        .w_n (w_n),
        .g_n (g_n),
        .ub_n(ub_n),
        .lb_n(lb_n),
        .addr(addr),
        .dqu (dqu),
        .dql (dql)
    );

    // k-th block of the whole sweep with loops laid end to end
    function automatic logic [ADDR_W-1:0] block_of(input int k);
        return BLOCK_FIRST + ADDR_W'(k % NBLK);
    endfunction

    function automatic logic [DATA_W-1:0] pattern_for(input logic [ADDR_W-1:0] blk,
                                                      input int loop);
        return (loop % 2 == 1) ? ~blk[15:0] : blk[15:0];  // odd loops inverted
    endfunction

    // what the faulty cell really holds after the write
    function automatic logic [DATA_W-1:0] stored_word(input logic [ADDR_W-1:0] blk,
                                                      input int loop);
        return pattern_for(blk, loop) | ((blk == FAULT_ADDR) ? STUCK_MASK : 16'h0000);
    endfunction

    // stuck bits that land on a zero of the pattern
    function automatic int expected_bad(input logic [ADDR_W-1:0] blk, input int loop);
        logic [DATA_W-1:0] miss;
        int                n;
        miss = (blk == FAULT_ADDR) ? (STUCK_MASK & ~pattern_for(blk, loop)) : 16'h0000;
        n    = 0;
        for (int i = 0; i < DATA_W; i++)
            n = n + int'(miss[i]);
        return n;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp)
        else
            abort_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_idle_pins();
        check_value("e_n", 32'(e_n), 32'd1);
        check_value("w_n", 32'(w_n), 32'd1);
        check_value("g_n", 32'(g_n), 32'd1);
        check_value("ub_n", 32'(ub_n), 32'd1);
        check_value("lb_n", 32'(lb_n), 32'd1);
        check_value("tx", 32'(tx), 32'd1);
        check_value("fail", 32'(fail), 32'd0);
        check_value("run_done", 32'(run_done), 32'd0);
    endtask

    task automatic check_write();
        logic [ADDR_W-1:0] blk;
        int                loop;
        blk  = block_of(wr_count);
        loop = wr_count / NBLK;
        assert (wr_count < RECORDS / 2)
        else
            abort_run("write cycle after the sweep should have ended");
        assert (addr >= BLOCK_FIRST && addr <= BLOCK_LAST)
        else
            abort_run($sformatf("write address %h outside the block range", addr));
        check_value("e_n at write", 32'(e_n), 32'd0);
        check_value("g_n at write", 32'(g_n), 32'd1);
        check_value("ub_n at write", 32'(ub_n), 32'd0);
        check_value("lb_n at write", 32'(lb_n), 32'd0);
        check_value("write addr", 32'(addr), 32'(blk));    // ascending order
        check_value("write dq", 32'({dqu, dql}), 32'(pattern_for(blk, loop)));
        wr_count++;
    endtask

    task automatic check_read();
        logic [ADDR_W-1:0] blk;
        int                loop;
        blk        = block_of(rd_count);
        loop       = rd_count / NBLK;
        model_word = {dqu, dql};                           // reported back in the record
        assert (rd_count < RECORDS / 2)
        else
            abort_run("read cycle after the sweep should have ended");
        check_value("e_n at read", 32'(e_n), 32'd0);
        check_value("w_n at read", 32'(w_n), 32'd1);
        check_value("ub_n at read", 32'(ub_n), 32'd0);
        check_value("lb_n at read", 32'(lb_n), 32'd0);
        check_value("read addr", 32'(addr), 32'(blk));
        check_value("read dq", 32'(model_word), 32'(stored_word(blk, loop)));
        rd_count++;
    endtask

    task automatic check_record();
        logic [7:0]        exp_bytes [REPORT_BYTES];
        logic [ADDR_W-1:0] blk;
        logic [LOOP_W-1:0] fld;
        int                loop;
        int                bad;
        bit                is_rd;
        is_rd = (rec_count % 2) == 1;                      // write first and read-back second
        blk   = block_of(rec_count / 2);
        loop  = (rec_count / 2) / NBLK;
        fld   = is_rd ? 32'(model_word) : 32'(loop);
        bad   = is_rd ? expected_bad(blk, loop) : 0;
        exp_bytes[0]  = is_rd ? 8'h01 : 8'h00;
        exp_bytes[1]  = 8'h00;
        exp_bytes[2]  = {6'd0, blk[17:16]};
        exp_bytes[3]  = blk[15:8];
        exp_bytes[4]  = blk[7:0];
        exp_bytes[5]  = fld[31:24];                        // msb first
        exp_bytes[6]  = fld[23:16];
        exp_bytes[7]  = fld[15:8];
        exp_bytes[8]  = fld[7:0];
        exp_bytes[9]  = 8'h00;
        exp_bytes[10] = 8'(bad);
        exp_bytes[11] = REPORT_END;
        for (int i = 0; i < REPORT_BYTES; i++)
            check_value($sformatf("record %0d byte %0d", rec_count, i),
                        32'(rec_bytes[i]), 32'(exp_bytes[i]));
        check_value("fail before record end", 32'(fail), 32'(nonzero_seen));
        if (bad != 0)
            nonzero_seen = 1'b1;
    endtask

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    initial
    begin
        rst          = 1'b1;
        wr_count     = 0;
        rd_count     = 0;
        rec_count    = 0;
        model_word   = '0;
        nonzero_seen = 1'b0;
        run_seen     = 1'b0;
        w_prev       = 1'b1;
        g_prev       = 1'b1;
        repeat (5)
        begin
            @(posedge clk);
            #1;
            check_idle_pins();                             // pins quiet under reset
        end
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_idle_pins();
        wait (run_done);
        repeat (TAIL) @(posedge clk);                      // look for stray traffic
        if (rec_count == RECORDS && wr_count == RECORDS / 2 && rd_count == RECORDS / 2)
        begin
            $display("all tests passed");
            $finish;
        end
        else
            abort_run($sformatf("run ended with %0d records, %0d writes, %0d reads",
                                rec_count, wr_count, rd_count));
    end

    // bus and status monitor sampling mid-cycle
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (!w_n && w_prev)
                check_write();
            if (!g_n && g_prev)
                check_read();
            if (run_done)
                run_seen = 1'b1;
            if (run_seen)
            begin
                check_value("run_done held", 32'(run_done), 32'd1);
                check_value("records at run_done", 32'(rec_count), 32'(RECORDS));
                check_value("e_n after run", 32'(e_n), 32'd1);
                check_value("tx after run", 32'(tx), 32'd1);
            end
            assert (!fail || nonzero_seen)
            else
                abort_run("fail rose before any record reported bad bits");
        end
        w_prev = w_n;
        g_prev = g_n;
    end

    // 8N1 decoder sampling each bit near its middle
    initial
    begin : serial_rx
        logic [7:0] rx_byte;
        wait (!rst);
        forever
        begin
            @(negedge tx);
            #(BIT_NS / 2 + 1);
            assert (tx == 1'b0)
            else
                abort_run("serial start bit did not stay low");
            for (int b = 0; b < 8; b++)
            begin
                #(BIT_NS);
                rx_byte[b] = tx;                           // lsb first
            end
            #(BIT_NS);
            assert (tx == 1'b1)
            else
                abort_run("serial stop bit missing");
            rec_bytes.push_back(rx_byte);
            if (rec_bytes.size() == REPORT_BYTES)
            begin
                check_record();
                rec_bytes.delete();
                rec_count++;
            end
        end
    end

    initial
    begin
        repeat (LIMIT) @(posedge clk);
        abort_run("timeout, run_done did not rise in time");
    end

endmodule

/* verif/mram_model.sv */
`timescale 1ns/10ps

module mram_model
    import mram_test_pkg::*;
#(
    parameter logic [ADDR_W-1:0] FAULT_ADDR = 18'h00401,
    parameter logic [DATA_W-1:0] STUCK_MASK = 16'h0009
)
(
    input  logic              e_n,
    input  logic              w_n,
    input  logic              g_n,
    input  logic              ub_n,
    input  logic              lb_n,
    input  logic [ADDR_W-1:0] addr,
    inout  wire  [7:0]        dqu,
    inout  wire  [7:0]        dql
);

    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];  // only written words live here
    logic [DATA_W-1:0] rd_word;
    logic [DATA_W-1:0] wr_word;
    logic [DATA_W-1:0] old_word;

    // unwritten cells, every address bit takes part
    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
        return a[15:0] ^ {a[17:16], 14'h1d35};
    endfunction

    // write follows the strobes while e_n and w_n are both low
    always @(e_n or w_n or ub_n or lb_n or addr or dqu or dql)
    begin
        if (!e_n && !w_n)
        begin
            old_word = mem.exists(addr) ? mem[addr] : fill_word(addr);
            wr_word  = {ub_n ? old_word[15:8] : dqu, lb_n ? old_word[7:0] : dql};
            if (addr == FAULT_ADDR)
                wr_word = wr_word | STUCK_MASK;  // stuck-at-one cells
            mem[addr] = wr_word;
        end
    end

    always @(e_n or g_n or addr)
    begin
        if (mem.exists(addr))
            rd_word = mem[addr];
        else
            rd_word = fill_word(addr);
    end

    assign dqu = (!e_n && !g_n && !ub_n) ? rd_word[15:8] : 8'hzz;  // output enable per lane
    assign dql = (!e_n && !g_n && !lb_n) ? rd_word[7:0]  : 8'hzz;

endmodule

/* hw/mram_tester_top.sv */
`timescale 1ns/10ps

module mram_tester_top
    import mram_test_pkg::*;
#(
    parameter logic [ADDR_W-1:0] BLOCK_FIRST  = 18'h00400,
    parameter logic [ADDR_W-1:0] BLOCK_LAST   = 18'h00403,
    parameter logic [LOOP_W-1:0] LOOP_COUNT   = 32'd2,
    parameter int                WR_PULSE     = 2,
    parameter int                RD_WAIT      = 2,
    parameter int                CLKS_PER_BIT = 4
)
(
    input  logic              clk,
    input  logic              rst,
    output logic              e_n,
    output logic              w_n,
    output logic              g_n,
    output logic              ub_n,
    output logic              lb_n,
    output logic [ADDR_W-1:0] addr,
    inout  wire  [7:0]        dqu,
    inout  wire  [7:0]        dql,
    output logic              tx,
    output logic              fail,
    output logic              run_done
);

    oper_e             op;
    logic [ADDR_W-1:0] block_addr;
    logic              invert;
    logic              start;
    logic              done;
    logic [DATA_W-1:0] read_word;
    logic [BAD_W-1:0]  bad_bits;           // engine result
    logic [BAD_W-1:0]  bad_hold;           // held for the record
    logic [LOOP_W-1:0] field;
    logic              send;
    logic              busy;
    logic [3:0]        byte_idx;
    mram_word_u        dq_out;
    mram_word_u        dq_in;
    logic              dq_oe;

    // byte lanes onto the split data pins
    assign dqu   = dq_oe ? dq_out.lane.upper : 8'hzz;
    assign dql   = dq_oe ? dq_out.lane.lower : 8'hzz;
    assign dq_in = {dqu, dql};             // upper lane is the high byte

    mram_test_seq #(
        .BLOCK_FIRST(BLOCK_FIRST),
        .BLOCK_LAST (BLOCK_LAST),
        .LOOP_COUNT (LOOP_COUNT)
    ) u_seq (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .block_addr(block_addr),
        .invert    (invert),
        .start     (start),
        .done      (done),
        .read_word (read_word),
        .bad_bits  (bad_bits),
        .field     (field),
        .bad_hold  (bad_hold),
        .send      (send),
        .byte_idx  (byte_idx),
        .busy      (busy),
        .fail      (fail),
        .run_done  (run_done)
    );

    mram_bus_engine #(
        .WR_PULSE(WR_PULSE),
        .RD_WAIT (RD_WAIT)
    ) u_engine (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .block_addr(block_addr),
        .invert    (invert),
        .start     (start),
        .done      (done),
        .read_word (read_word),
        .bad_bits  (bad_bits),
        .e_n       (e_n),
        .w_n       (w_n),
        .g_n       (g_n),
        .ub_n      (ub_n),
        .lb_n      (lb_n),
        .addr      (addr),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .dq_in     (dq_in)
    );

    report_uart #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_report (
        .clk       (clk),
        .rst       (rst),
        .send      (send),
        .byte_idx  (byte_idx),
        .op        (op),
        .block_addr(block_addr),
        .field     (field),
        .bad_bits  (bad_hold),
        .busy      (busy),
        .tx        (tx)
    );

endmodule

/* hw/report_uart.sv */
`timescale 1ns/10ps

module report_uart
    import mram_test_pkg::*;
#(
    parameter int CLKS_PER_BIT = 4
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              send,
    input  logic [3:0]        byte_idx,
    input  oper_e             op,
    input  logic [ADDR_W-1:0] block_addr,
    input  logic [LOOP_W-1:0] field,
    input  logic [BAD_W-1:0]  bad_bits,
    output logic              busy,
    output logic              tx
);

    localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic [7:0]        byte_sel;           // record byte for byte_idx
    logic [7:0]        shreg;              // data bits still to go
    logic [BAUD_W-1:0] baud;               // clocks within current bit
    logic [3:0]        bit_cnt;            // bits finished, start bit is 0
    logic              bit_end;

    // record layout, msb first for multi-byte fields
    always_comb
    begin
        case (byte_idx)
            4'd0:    byte_sel = 8'(op);
            4'd1:    byte_sel = 8'h00;
            4'd2:    byte_sel = 8'(block_addr[ADDR_W-1:16]);
            4'd3:    byte_sel = block_addr[15:8];
            4'd4:    byte_sel = block_addr[7:0];
            4'd5:    byte_sel = field[31:24];  // loop count or read word
            4'd6:    byte_sel = field[23:16];
            4'd7:    byte_sel = field[15:8];
            4'd8:    byte_sel = field[7:0];
            4'd9:    byte_sel = 8'h00;
            4'd10:   byte_sel = 8'(bad_bits);
            4'(REPORT_BYTES - 1):
                     byte_sel = REPORT_END;
            default: byte_sel = 8'h00;
        endcase
    end

    assign bit_end = busy && (baud == BAUD_W'(CLKS_PER_BIT - 1));

    // shifter, lsb first, fills with stop level
    always_ff @(posedge clk)
    begin
        if (send && !busy)
            shreg <= byte_sel;
        else if (bit_end && bit_cnt != 4'd9)
            shreg <= {1'b1, shreg[7:1]};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy    <= 1'b0;
            tx      <= 1'b1;               // line idles high
            baud    <= '0;
            bit_cnt <= '0;
        end
        else if (!busy)
        begin
            if (send)
            begin
                busy    <= 1'b1;
                tx      <= 1'b0;           // start bit
                baud    <= '0;
                bit_cnt <= '0;
            end
        end
        else if (bit_end)
        begin
            baud <= '0;
            if (bit_cnt == 4'd9)
            begin
                busy <= 1'b0;              // stop bit done
                tx   <= 1'b1;
            end
            else
            begin
                tx      <= shreg[0];       // next data bit, then stop
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
        else
            baud <= baud + 1'b1;
    end

endmodule

/* hw/mram_bus_engine.sv */
`timescale 1ns/10ps

module mram_bus_engine
    import mram_test_pkg::*;
#(
    parameter int WR_PULSE = 2,
    parameter int RD_WAIT  = 2
)
(
    input  logic              clk,
    input  logic              rst,
    input  oper_e             op,
    input  logic [ADDR_W-1:0] block_addr,
    input  logic              invert,
    input  logic              start,
    output logic              done,
    output logic [DATA_W-1:0] read_word,
    output logic [BAD_W-1:0]  bad_bits,
    output logic              e_n,
    output logic              w_n,
    output logic              g_n,
    output logic              ub_n,
    output logic              lb_n,
    output logic [ADDR_W-1:0] addr,
    output mram_word_u        dq_out,
    output logic              dq_oe,
    input  mram_word_u        dq_in
);

    localparam int CNT_MAX = (WR_PULSE > RD_WAIT) ? WR_PULSE : RD_WAIT;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    localparam logic [1:0] E_IDLE = 2'd0;  // strobes high
    localparam logic [1:0] E_WR   = 2'd1;  // w_n low
    localparam logic [1:0] E_RD   = 2'd2;  // g_n low while data settles
    localparam logic [1:0] E_REC  = 2'd3;  // recovery with strobes high

    logic [1:0]       state;
    logic [CNT_W-1:0] cnt;                 // strobe cycle counter
    logic             wr_last;
    logic             rd_last;
    mram_word_u       pattern;             // expected word for this block
    mram_word_u       rd_q;                // sampled read data

    // number of set bits in a word
    function automatic logic [BAD_W-1:0] count_ones(input logic [DATA_W-1:0] v);
        logic [BAD_W-1:0] n;
        n = '0;
        for (int i = 0; i < DATA_W; i++)
            n = n + BAD_W'(v[i]);
        return n;
    endfunction

    assign pattern.word = block_addr[DATA_W-1:0] ^ {DATA_W{invert}};
    assign wr_last      = (cnt == CNT_W'(WR_PULSE - 1));
    assign rd_last      = (cnt == CNT_W'(RD_WAIT - 1));
    assign read_word    = rd_q.word;

    // bus address, write data and results
    always_ff @(posedge clk)
    begin
        if (state == E_IDLE && start)
        begin
            addr   <= block_addr;
            dq_out <= pattern;             // write data doubles as compare value
        end
        if (state == E_RD && rd_last)
            rd_q <= dq_in;                 // last cycle with g_n low
        if (state == E_REC)
            bad_bits <= (op == OP_RD) ? count_ones(rd_q.word ^ dq_out.word) : '0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= E_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
            e_n   <= 1'b1;
            w_n   <= 1'b1;
            g_n   <= 1'b1;
            ub_n  <= 1'b1;
            lb_n  <= 1'b1;
            dq_oe <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                E_IDLE:
                begin
                    if (start)
                    begin
                        cnt  <= '0;
                        e_n  <= 1'b0;      // chip enable and both lanes
                        ub_n <= 1'b0;
                        lb_n <= 1'b0;
                        if (op == OP_RD)
                        begin
                            g_n   <= 1'b0;
                            state <= E_RD;
                        end
                        else
                        begin
                            w_n   <= 1'b0;
                            dq_oe <= 1'b1; // drive dq only with w_n low
                            state <= E_WR;
                        end
                    end
                end
                E_WR:
                begin
                    if (wr_last)
                    begin
                        e_n   <= 1'b1;
                        w_n   <= 1'b1;
                        ub_n  <= 1'b1;
                        lb_n  <= 1'b1;
                        dq_oe <= 1'b0;
                        state <= E_REC;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                E_RD:
                begin
                    if (rd_last)
                    begin
                        e_n   <= 1'b1;
                        g_n   <= 1'b1;
                        ub_n  <= 1'b1;
                        lb_n  <= 1'b1;
                        state <= E_REC;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                E_REC:
                begin
                    done  <= 1'b1;         // bad_bits lands with done
                    state <= E_IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/mram_test_seq.sv */
`timescale 1ns/10ps

module mram_test_seq
    import mram_test_pkg::*;
#(
    parameter logic [ADDR_W-1:0] BLOCK_FIRST = 18'h00400,
    parameter logic [ADDR_W-1:0] BLOCK_LAST  = 18'h00403,
    parameter logic [LOOP_W-1:0] LOOP_COUNT  = 32'd2
)
(
    input  logic              clk,
    input  logic              rst,
    output oper_e             op,
    output logic [ADDR_W-1:0] block_addr,
    output logic              invert,
    output logic              start,
    input  logic              done,
    input  logic [DATA_W-1:0] read_word,
    input  logic [BAD_W-1:0]  bad_bits,
    output logic [LOOP_W-1:0] field,
    output logic [BAD_W-1:0]  bad_hold,
    output logic              send,
    output logic [3:0]        byte_idx,
    input  logic              busy,
    output logic              fail,
    output logic              run_done
);

    localparam logic [2:0] S_START     = 3'd0;  // pulse start to engine
    localparam logic [2:0] S_WAIT      = 3'd1;  // memory cycle in flight
    localparam logic [2:0] S_SEND      = 3'd2;  // pulse send for byte_idx
    localparam logic [2:0] S_TX        = 3'd3;  // wait for busy to drop
    localparam logic [2:0] S_NEXT_OP   = 3'd4;  // write -> read
    localparam logic [2:0] S_NEXT_BLK  = 3'd5;  // next block
    localparam logic [2:0] S_NEXT_LOOP = 3'd6;  // next full loop
    localparam logic [2:0] S_END       = 3'd7;  // hold forever

    logic [2:0]        state;
    logic [LOOP_W-1:0] loop_cnt;               // loops completed so far
    logic [DATA_W-1:0] read_hold;              // read word for the record

    assign invert = loop_cnt[0];               // odd loops write ~pattern
    assign field  = (op == OP_WR) ? loop_cnt : LOOP_W'(read_hold);

    // result latch, held for the whole record
    always_ff @(posedge clk)
    begin
        if (state == S_WAIT && done)
        begin
            read_hold <= read_word;
            bad_hold  <= bad_bits;             // zero for writes
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= S_START;
            op         <= OP_WR;
            block_addr <= BLOCK_FIRST;
            loop_cnt   <= '0;
            start      <= 1'b0;
            send       <= 1'b0;
            byte_idx   <= '0;
            fail       <= 1'b0;
            run_done   <= 1'b0;
        end
        else
        begin
            start <= 1'b0;                     // both strobes are single pulses
            send  <= 1'b0;
            case (state)
                S_START:
                begin
                    start <= 1'b1;
                    state <= S_WAIT;
                end
                S_WAIT:
                begin
                    if (done)
                    begin
                        byte_idx <= '0;
                        state    <= S_SEND;
                    end
                end
                S_SEND:
                begin
                    send  <= 1'b1;
                    state <= S_TX;
                end
                S_TX:
                begin
                    // busy only shows up the cycle after send
                    if (!send && !busy)
                    begin
                        if (byte_idx == 4'(REPORT_BYTES - 1))
                        begin
                            fail  <= fail | (bad_hold != '0);  // sticky, after report
                            state <= S_NEXT_OP;
                        end
                        else
                        begin
                            byte_idx <= byte_idx + 4'd1;
                            state    <= S_SEND;
                        end
                    end
                end
                S_NEXT_OP:
                begin
                    if (op == OP_WR)
                    begin
                        op    <= OP_RD;                // read back same block
                        state <= S_START;
                    end
                    else
                    begin
                        op    <= OP_WR;
                        state <= S_NEXT_BLK;
                    end
                end
                S_NEXT_BLK:
                begin
                    if (block_addr == BLOCK_LAST)
                        state <= S_NEXT_LOOP;
                    else
                    begin
                        block_addr <= block_addr + 1'b1;
                        state      <= S_START;
                    end
                end
                S_NEXT_LOOP:
                begin
                    if (loop_cnt == LOOP_COUNT - 1'b1)
                    begin
                        run_done <= 1'b1;              // sweep finished
                        state    <= S_END;
                    end
                    else
                    begin
                        loop_cnt   <= loop_cnt + 1'b1; // flips pattern parity
                        block_addr <= BLOCK_FIRST;
                        state      <= S_START;
                    end
                end
                S_END:
                    state <= S_END;                    // no more bus or serial traffic
            endcase
        end
    end

endmodule

/* hw/mram_test_pkg.sv */
package mram_test_pkg;

    localparam int ADDR_W = 18;            // mram address pins
    localparam int DATA_W = 16;            // dqu + dql
    localparam int LOOP_W = 32;            // full-loop counter
    localparam int BAD_W  = 5;             // 0..16 bad bits

    localparam int         REPORT_BYTES = 12;     // bytes per record
    localparam logic [7:0] REPORT_END   = 8'hEE;  // last byte of a record

    // operation code, also byte 0 of the record
    typedef enum logic [1:0] {
        OP_WR = 2'd0,
        OP_RD = 2'd1
    } oper_e;

    // upper/lower byte lanes map onto dqu/dql
    typedef struct packed {
        logic [7:0] upper;                 // dqu, ub_n lane
        logic [7:0] lower;                 // dql, lb_n lane
    } mram_lanes_t;

    // one data word, seen whole or as two lanes
    typedef union packed {
        logic [DATA_W-1:0] word;           // pattern / compare view
        mram_lanes_t       lane;           // pin view
    } mram_word_u;

endpackage
